//--- rv_pipeline.f
pipe_pkg.sv
pipe_reg.sv
fetch_stage.sv
reg_file.sv
decoder.sv
exec_stage.sv
hazard_unit.sv
data_mem.sv
rv_pipeline.sv
rv_pipeline_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
    -f rv_pipeline.f --top-module rv_pipeline_tb -o rv_pipeline_sim

./obj_dir/rv_pipeline_sim | tee sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

//--- rv_pipeline_tb.sv
`timescale 1ns/100ps

module rv_pipeline_tb import pipe_pkg::*; ();

    localparam int IMEM_DEPTH    = 64;
    localparam int DMEM_DEPTH    = 16;
    localparam int BODY_LEN      = 40;
    localparam int EVENT_TIMEOUT = 60;     // Cycles without any trace event
    localparam int QUIET_CYCLES  = 20;

    // Instruction kinds, writers first
    localparam int K_ADD  = 0;
    localparam int K_SUB  = 1;
    localparam int K_AND  = 2;
    localparam int K_OR   = 3;
    localparam int K_SLT  = 4;
    localparam int K_ADDI = 5;
    localparam int K_LW   = 6;
    localparam int K_SW   = 7;
    localparam int K_BEQ  = 8;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } wb_event_t;

    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] data;
    } st_event_t;

    logic                  clk;
    logic                  rst;
    logic                  imem_we;
    logic [XLEN-1:0]       imem_addr;
    logic [XLEN-1:0]       imem_wdata;
    logic                  wb_valid;
    logic [REG_ADDR_W-1:0] wb_rd;
    logic [XLEN-1:0]       wb_data;
    logic                  st_valid;
    logic [XLEN-1:0]       st_addr;
    logic [XLEN-1:0]       st_data;

    int              prog_kind [IMEM_DEPTH];
    int              prog_rd   [IMEM_DEPTH];
    int              prog_rs1  [IMEM_DEPTH];
    int              prog_rs2  [IMEM_DEPTH];
    int              prog_imm  [IMEM_DEPTH];
    logic [XLEN-1:0] prog_word [IMEM_DEPTH];
    int              end_idx;              // Index of the self-loop

    wb_event_t exp_wb [$];
    st_event_t exp_st [$];
    int        exp_wb_cyc [$];             // Cycle after reset release
    int        exp_st_cyc [$];
    int        wb_errors;
    int        st_errors;
    int        cyc_errors;
    int        other_errors;
    int        wb_idx;
    int        st_idx;
    bit        timed_out;

    rv_pipeline #(
        .IMEM_DEPTH (IMEM_DEPTH),
        .DMEM_DEPTH (DMEM_DEPTH)
    ) rv_pipeline_i (
        .clk        (clk),
        .rst        (rst),
        .imem_we    (imem_we),
        .imem_addr  (imem_addr),
        .imem_wdata (imem_wdata),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data),
        .st_valid   (st_valid),
        .st_addr    (st_addr),
        .st_data    (st_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // RV32I base encodings
    function automatic logic [XLEN-1:0] encode(input int kind, input int rd, input int rs1,
                                               input int rs2, input int imm);
        logic [4:0]      d;
        logic [4:0]      s1;
        logic [4:0]      s2;
        logic [XLEN-1:0] im;
        d  = 5'(rd);
        s1 = 5'(rs1);
        s2 = 5'(rs2);
        im = imm;
        case (kind)
            K_ADD:   return {7'b0000000, s2, s1, 3'b000, d, 7'b0110011};
            K_SUB:   return {7'b0100000, s2, s1, 3'b000, d, 7'b0110011};
            K_AND:   return {7'b0000000, s2, s1, 3'b111, d, 7'b0110011};
            K_OR:    return {7'b0000000, s2, s1, 3'b110, d, 7'b0110011};
            K_SLT:   return {7'b0000000, s2, s1, 3'b010, d, 7'b0110011};
            K_ADDI:  return {im[11:0], s1, 3'b000, d, 7'b0010011};
            K_LW:    return {im[11:0], s1, 3'b010, d, 7'b0000011};
            K_SW:    return {im[11:5], s2, s1, 3'b010, im[4:0], 7'b0100011};
            default: return {im[12], im[10:5], s2, s1, 3'b000, im[4:1], im[11], 7'b1100011};
        endcase
    endfunction

    // Kinds that take a second source register
    function automatic bit reads_rs2(input int kind);
        return kind <= K_SLT || kind == K_SW || kind == K_BEQ;
    endfunction

    task automatic put_instr(input int p, input int kind, input int rd, input int rs1,
                             input int rs2, input int imm);
        prog_kind[p] = kind;
        prog_rd[p]   = rd;
        prog_rs1[p]  = rs1;
        prog_rs2[p]  = rs2;
        prog_imm[p]  = imm;
        prog_word[p] = encode(kind, rd, rs1, rs2, imm);
    endtask

    task automatic build_program();
        int         p;
        int         kind;
        int         k;
        int         imm;
        int         rs1;
        int         rs2;
        logic [11:0] i12;
        p = 0;
        put_instr(p, K_ADDI, 0, 0, 0, 11);     // x0 write, read back right after
        p++;
        for (int w = 0; w < DMEM_DEPTH; w++) begin
            if (w % 4 == 0) begin
                i12 = 12'($urandom);
                put_instr(p, K_ADDI, 1 + w / 4, 0, 0, int'($signed(i12)));
                p++;
            end
            put_instr(p, K_SW, 0, 0, 1 + w / 4, 4 * w);
            p++;
        end
        end_idx = p + BODY_LEN;
        for (int n = 0; n < BODY_LEN; n++) begin
            kind = int'($urandom % 10);
            if (kind == 9) kind = K_LW;    // Extra loads for load-use cases
            rs1 = int'($urandom % 8);
            rs2 = int'($urandom % 8);
            imm = 0;
            if (kind == K_ADDI) begin
                i12 = 12'($urandom);
                imm = int'($signed(i12));
            end else if (kind == K_LW || kind == K_SW) begin
                imm = 4 * int'($urandom % 16);
            end else if (kind == K_BEQ) begin
                k = 1 + int'($urandom % 3);
                if (k > end_idx - p) k = end_idx - p;
                imm = 4 * k;
                if ($urandom % 2 == 0) rs2 = rs1;     // Make taken branches common
            end
            put_instr(p, kind, int'($urandom % 8), rs1, rs2, imm);
            p++;
        end
        put_instr(end_idx, K_BEQ, 0, 0, 0, 0);
        for (int i = end_idx + 1; i < IMEM_DEPTH; i++) begin
            put_instr(i, K_ADDI, 0, 0, 0, i);     // NOP fill with the word index
        end
    endtask

    // ISA-level reference, one instruction per step
    task automatic run_model();
        logic [XLEN-1:0] regs [32];
        logic [XLEN-1:0] dmem [DMEM_DEPTH];
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] pc_next;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] im;
        logic [XLEN-1:0] res;
        int              idx;
        int              nxt;
        int              widx;
        int              steps;
        int              e_cyc;
        bit              taken;
        wb_event_t       wev;
        st_event_t       sev;
        foreach (regs[i]) regs[i] = '0;
        foreach (dmem[i]) dmem[i] = '0;
        pc    = '0;
        steps = 0;
        e_cyc = 2;                          // First instruction in execute
        while (pc != XLEN'(end_idx * 4) && steps < 500) begin
            idx     = int'(pc >> 2);
            a       = regs[prog_rs1[idx]];
            b       = regs[prog_rs2[idx]];
            im      = prog_imm[idx];
            widx    = int'(((a + im) >> 2) % DMEM_DEPTH);
            pc_next = pc + 4;
            res     = '0;
            taken   = 1'b0;
            case (prog_kind[idx])
                K_ADD:  res = a + b;
                K_SUB:  res = a - b;
                K_AND:  res = a & b;
                K_OR:   res = a | b;
                K_SLT:  res = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
                K_ADDI: res = a + im;
                K_LW:   res = dmem[widx];
                K_SW: begin
                    sev.addr = a + im;
                    sev.data = b;
                    exp_st.push_back(sev);
                    exp_st_cyc.push_back(e_cyc + 1);
                    dmem[widx] = b;
                end
                default: begin
                    if (a == b) begin
                        pc_next = pc + im;
                        taken   = 1'b1;
                    end
                end
            endcase
            if (prog_kind[idx] <= K_LW && prog_rd[idx] != 0) begin
                regs[prog_rd[idx]] = res;
                wev.rd   = REG_ADDR_W'(prog_rd[idx]);
                wev.data = res;
                exp_wb.push_back(wev);
                exp_wb_cyc.push_back(e_cyc + 2);
            end
            nxt   = idx + 1;
            e_cyc = e_cyc + 1;
            if (taken) begin
                e_cyc = e_cyc + 2;          // Two younger slots discarded
            end else if (prog_kind[idx] == K_LW && prog_rd[idx] != 0 &&
                         (prog_rs1[nxt] == prog_rd[idx] ||
                          (reads_rs2(prog_kind[nxt]) && prog_rs2[nxt] == prog_rd[idx]))) begin
                e_cyc = e_cyc + 1;          // Load-use bubble
            end
            pc = pc_next;
            steps++;
        end
        if (steps >= 500) begin
            other_errors++;
            $display("Reference model did not reach the end of the program");
        end
    endtask

    task automatic check_wb(input string name, input wb_event_t exp, input wb_event_t act);
        if (exp !== act) begin
            wb_errors++;
            $display("FAILED %s: expected x%0d = %08h, actual x%0d = %08h",
                     name, exp.rd, exp.data, act.rd, act.data);
        end
    endtask

    task automatic check_store(input string name, input st_event_t exp, input st_event_t act);
        if (exp !== act) begin
            st_errors++;
            $display("FAILED %s: expected [%08h] = %08h, actual [%08h] = %08h",
                     name, exp.addr, exp.data, act.addr, act.data);
        end
    endtask

    task automatic check_cycle(input string name, input int exp, input int act);
        if (exp != act) begin
            cyc_errors++;
            $display("FAILED %s: expected cycle %0d, actual cycle %0d", name, exp, act);
        end
    endtask

    // Program load through the write port, then the plain reset cycles
    task automatic load_and_reset();
        for (int i = 0; i < IMEM_DEPTH; i++) begin
            @(negedge clk);
            imem_we    = 1'b1;
            imem_addr  = XLEN'(i * 4);
            imem_wdata = prog_word[i];
        end
        @(negedge clk);
        imem_we = 1'b0;
        repeat (5) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic collect_events();
        int        idle;
        int        cyc;
        wb_event_t wact;
        st_event_t sact;
        idle = 0;
        cyc  = 0;
        while ((wb_idx < exp_wb.size() || st_idx < exp_st.size()) && !timed_out) begin
            @(negedge clk);
            idle++;
            cyc++;
            if (wb_valid) begin
                idle      = 0;
                wact.rd   = wb_rd;
                wact.data = wb_data;
                if (wb_idx < exp_wb.size()) begin
                    check_wb($sformatf("writeback %0d", wb_idx), exp_wb[wb_idx], wact);
                    check_cycle($sformatf("writeback %0d timing", wb_idx),
                                exp_wb_cyc[wb_idx], cyc);
                end else begin
                    other_errors++;
                    $display("Extra writeback to x%0d after the expected stream", wb_rd);
                end
                wb_idx++;
            end
            if (st_valid) begin
                idle      = 0;
                sact.addr = st_addr;
                sact.data = st_data;
                if (st_idx < exp_st.size()) begin
                    check_store($sformatf("store %0d", st_idx), exp_st[st_idx], sact);
                    check_cycle($sformatf("store %0d timing", st_idx),
                                exp_st_cyc[st_idx], cyc);
                end else begin
                    other_errors++;
                    $display("Extra store to %08h after the expected stream", st_addr);
                end
                st_idx++;
            end
            if (idle > EVENT_TIMEOUT) begin
                other_errors++;
                timed_out = 1'b1;
                $display("Timeout after %0d idle cycles, %0d writebacks and %0d stores seen",
                         EVENT_TIMEOUT, wb_idx, st_idx);
            end
        end
    endtask

    task automatic check_quiet();
        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            if (wb_valid || st_valid) begin
                other_errors++;
                $display("Trace event while the program sits in its final loop");
            end
        end
    endtask

    initial begin
        rst          = 1'b1;
        imem_we      = 1'b0;
        imem_addr    = '0;
        imem_wdata   = '0;
        wb_errors    = 0;
        st_errors    = 0;
        cyc_errors   = 0;
        other_errors = 0;
        wb_idx       = 0;
        st_idx       = 0;
        timed_out    = 1'b0;
        void'($urandom(41145));
        build_program();
        run_model();
        $display("Expecting %0d writebacks and %0d stores", exp_wb.size(), exp_st.size());
        load_and_reset();
        collect_events();
        if (!timed_out) begin
            check_quiet();
        end
        $display("Errors: writeback %0d, store %0d, timing %0d, other %0d",
                 wb_errors, st_errors, cyc_errors, other_errors);
        if (wb_errors + st_errors + cyc_errors + other_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- rv_pipeline.sv
`timescale 1ns/100ps

module rv_pipeline import pipe_pkg::*; #(
    parameter int IMEM_DEPTH = 64,
    parameter int DMEM_DEPTH = 16
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  imem_we,
    input  logic [XLEN-1:0]       imem_addr,
    input  logic [XLEN-1:0]       imem_wdata,
    output logic                  wb_valid,
    output logic [REG_ADDR_W-1:0] wb_rd,
    output logic [XLEN-1:0]       wb_data,
    output logic                  st_valid,
    output logic [XLEN-1:0]       st_addr,
    output logic [XLEN-1:0]       st_data
);

    fd_t fd_d, fd_q;
    de_t de_d, de_q;
    em_t em_d, em_q;
    mw_t mw_d, mw_q;

    ctrl_t                 ctrl_d;
    logic [XLEN-1:0]       imm_d;
    logic [XLEN-1:0]       rd1_d;
    logic [XLEN-1:0]       rd2_d;
    logic [REG_ADDR_W-1:0] rs1_d;
    logic [REG_ADDR_W-1:0] rs2_d;
    logic [REG_ADDR_W-1:0] rd_d;

    fwd_sel_e        forward_a;
    fwd_sel_e        forward_b;
    logic            stall_f;
    logic            stall_d;
    logic            flush_d;
    logic            flush_e;
    logic            pc_src;
    logic [XLEN-1:0] pc_target;
    logic            dmem_we;
    logic [XLEN-1:0] read_data_m;
    logic [XLEN-1:0] result_w;

    fetch_stage #(.IMEM_DEPTH(IMEM_DEPTH)) fetch_i (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall_f),
        .pc_src     (pc_src),
        .pc_target  (pc_target),
        .imem_we    (imem_we),
        .imem_addr  (imem_addr),
        .imem_wdata (imem_wdata),
        .fd         (fd_d)
    );

    pipe_reg #(.T(fd_t)) fd_reg_i (
        .clk(clk), .rst(rst), .stall(stall_d), .flush(flush_d), .d(fd_d), .q(fd_q)
    );

    decoder decoder_i (
        .fd(fd_q), .ctrl(ctrl_d), .imm(imm_d), .rs1(rs1_d), .rs2(rs2_d), .rd(rd_d)
    );

    reg_file reg_file_i (
        .clk (clk),
        .rst (rst),
        .ra1 (rs1_d),
        .ra2 (rs2_d),
        .rd1 (rd1_d),
        .rd2 (rd2_d),
        .we  (mw_q.valid && mw_q.reg_write),
        .wa  (mw_q.rd),
        .wd  (result_w)
    );

    assign de_d.ctrl  = ctrl_d;
    assign de_d.valid = fd_q.valid;
    assign de_d.pc    = fd_q.pc;
    assign de_d.rd1   = rd1_d;
    assign de_d.rd2   = rd2_d;
    assign de_d.rs1   = rs1_d;
    assign de_d.rs2   = rs2_d;
    assign de_d.rd    = rd_d;
    assign de_d.imm   = imm_d;

    pipe_reg #(.T(de_t)) de_reg_i (
        .clk(clk), .rst(rst), .stall(1'b0), .flush(flush_e), .d(de_d), .q(de_q)
    );

    exec_stage exec_i (
        .de        (de_q),
        .forward_a (forward_a),
        .forward_b (forward_b),
        .mem_fwd   (em_q.alu_result),
        .wb_fwd    (result_w),
        .em        (em_d),
        .pc_src    (pc_src),
        .pc_target (pc_target)
    );

    pipe_reg #(.T(em_t)) em_reg_i (
        .clk(clk), .rst(rst), .stall(1'b0), .flush(1'b0), .d(em_d), .q(em_q)
    );

    assign dmem_we = em_q.valid && em_q.mem_write;

    data_mem #(.DMEM_DEPTH(DMEM_DEPTH)) data_mem_i (
        .clk   (clk),
        .we    (dmem_we),
        .addr  (em_q.alu_result),
        .wdata (em_q.write_data),
        .rdata (read_data_m)
    );

    assign mw_d.reg_write  = em_q.reg_write;
    assign mw_d.result_src = em_q.result_src;
    assign mw_d.valid      = em_q.valid;
    assign mw_d.alu_result = em_q.alu_result;
    assign mw_d.read_data  = read_data_m;
    assign mw_d.rd         = em_q.rd;
    assign mw_d.pc_plus4   = em_q.pc_plus4;

    pipe_reg #(.T(mw_t)) mw_reg_i (
        .clk(clk), .rst(rst), .stall(1'b0), .flush(1'b0), .d(mw_d), .q(mw_q)
    );

    always_comb begin
        case (mw_q.result_src)
            RES_MEM: result_w = mw_q.read_data;
            RES_PC4: result_w = mw_q.pc_plus4;
            default: result_w = mw_q.alu_result;
        endcase
    end

    hazard_unit hazard_i (
        .rs1_d        (rs1_d),
        .rs2_d        (rs2_d),
        .rs1_e        (de_q.rs1),
        .rs2_e        (de_q.rs2),
        .rd_e         (de_q.rd),
        .rd_m         (em_q.rd),
        .rd_w         (mw_q.rd),
        .result_src_e (de_q.ctrl.result_src),
        .reg_write_m  (em_q.reg_write),
        .reg_write_w  (mw_q.reg_write),
        .pc_src       (pc_src),
        .forward_a    (forward_a),
        .forward_b    (forward_b),
        .stall_f      (stall_f),
        .stall_d      (stall_d),
        .flush_d      (flush_d),
        .flush_e      (flush_e)
    );

    assign wb_valid = mw_q.valid && mw_q.reg_write && (mw_q.rd != '0);
    assign wb_rd    = mw_q.rd;
    assign wb_data  = result_w;

    assign st_valid = dmem_we;
    assign st_addr  = em_q.alu_result;
    assign st_data  = em_q.write_data;

endmodule

//--- data_mem.sv
`timescale 1ns/100ps

module data_mem import pipe_pkg::*; #(
    parameter int DMEM_DEPTH = 16
) (
    input  logic            clk,
    input  logic            we,
    input  logic [XLEN-1:0] addr,       // Byte address
    input  logic [XLEN-1:0] wdata,
    output logic [XLEN-1:0] rdata
);

    localparam int DAW = $clog2(DMEM_DEPTH);

    logic [XLEN-1:0]  mem [DMEM_DEPTH];
    logic [DAW-1:0]   word_idx;

    assign word_idx = addr[DAW+1:2];    // Wraps at the depth

    always_ff @(posedge clk) begin
        if (we) begin
            mem[word_idx] <= wdata;
        end
    end

    assign rdata = mem[word_idx];

endmodule

//--- hazard_unit.sv
`timescale 1ns/100ps

module hazard_unit import pipe_pkg::*; (
    input  logic [REG_ADDR_W-1:0] rs1_d,
    input  logic [REG_ADDR_W-1:0] rs2_d,
    input  logic [REG_ADDR_W-1:0] rs1_e,
    input  logic [REG_ADDR_W-1:0] rs2_e,
    input  logic [REG_ADDR_W-1:0] rd_e,
    input  logic [REG_ADDR_W-1:0] rd_m,
    input  logic [REG_ADDR_W-1:0] rd_w,
    input  pipe_pkg::result_src_e result_src_e,
    input  logic                  reg_write_m,
    input  logic                  reg_write_w,
    input  logic                  pc_src,         // Taken branch in execute
    output fwd_sel_e              forward_a,
    output fwd_sel_e              forward_b,
    output logic                  stall_f,
    output logic                  stall_d,
    output logic                  flush_d,
    output logic                  flush_e
);

    logic lw_stall;

    function automatic fwd_sel_e fwd_select(
        input logic [REG_ADDR_W-1:0] rs,
        input logic [REG_ADDR_W-1:0] rd_mem,
        input logic                  we_mem,
        input logic [REG_ADDR_W-1:0] rd_wb,
        input logic                  we_wb
    );
        if (rs == '0) begin
            return FWD_REG;         // x0 is never forwarded
        end else if (we_mem && rs == rd_mem) begin
            return FWD_MEM;         // Youngest result first
        end else if (we_wb && rs == rd_wb) begin
            return FWD_WB;
        end
        return FWD_REG;
    endfunction

    assign forward_a = fwd_select(rs1_e, rd_m, reg_write_m, rd_w, reg_write_w);
    assign forward_b = fwd_select(rs2_e, rd_m, reg_write_m, rd_w, reg_write_w);

    // Load data arrives one stage too late for the next instruction
    assign lw_stall = (result_src_e == RES_MEM) && (rd_e != '0) &&
                      ((rd_e == rs1_d) || (rd_e == rs2_d));

    assign stall_f = lw_stall;
    assign stall_d = lw_stall;
    assign flush_d = pc_src;
    assign flush_e = lw_stall || pc_src;    // Bubble into execute

endmodule

//--- exec_stage.sv
`timescale 1ns/100ps

module exec_stage import pipe_pkg::*; (
    input  de_t             de,
    input  fwd_sel_e        forward_a,
    input  fwd_sel_e        forward_b,
    input  logic [XLEN-1:0] mem_fwd,
    input  logic [XLEN-1:0] wb_fwd,
    output em_t             em,
    output logic            pc_src,
    output logic [XLEN-1:0] pc_target
);

    logic [XLEN-1:0] src_a;
    logic [XLEN-1:0] rs2_val;
    logic [XLEN-1:0] src_b;
    logic [XLEN-1:0] alu_y;

    function automatic logic [XLEN-1:0] fwd_mux(
        input fwd_sel_e        sel,
        input logic [XLEN-1:0] reg_val,
        input logic [XLEN-1:0] wb_val,
        input logic [XLEN-1:0] mem_val
    );
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    assign src_a   = fwd_mux(forward_a, de.rd1, wb_fwd, mem_fwd);
    assign rs2_val = fwd_mux(forward_b, de.rd2, wb_fwd, mem_fwd);
    assign src_b   = de.ctrl.alu_src_imm ? de.imm : rs2_val;

    always_comb begin
        case (de.ctrl.alu_op)
            ALU_SUB: alu_y = src_a - src_b;
            ALU_AND: alu_y = src_a & src_b;
            ALU_OR:  alu_y = src_a | src_b;
            ALU_SLT: alu_y = {{(XLEN-1){1'b0}}, $signed(src_a) < $signed(src_b)};
            default: alu_y = src_a + src_b;     // Also address for LW and SW
        endcase
    end

    // BEQ compares the register operands, never the immediate
    assign pc_src    = de.valid && de.ctrl.branch && (src_a == rs2_val);
    assign pc_target = de.pc + de.imm;

    assign em.reg_write  = de.ctrl.reg_write;
    assign em.result_src = de.ctrl.result_src;
    assign em.mem_write  = de.ctrl.mem_write;
    assign em.valid      = de.valid;
    assign em.alu_result = alu_y;
    assign em.write_data = rs2_val;
    assign em.rd         = de.rd;
    assign em.pc_plus4   = de.pc + XLEN'(4);

endmodule

//--- decoder.sv
`timescale 1ns/100ps

module decoder import pipe_pkg::*; (
    input  fd_t                   fd,
    output ctrl_t                 ctrl,
    output logic [XLEN-1:0]       imm,
    output logic [REG_ADDR_W-1:0] rs1,
    output logic [REG_ADDR_W-1:0] rs2,
    output logic [REG_ADDR_W-1:0] rd
);

    localparam logic [6:0] OP_R      = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic            legal;
    logic            use_rs2;

    assign opcode = fd.instr[6:0];
    assign funct3 = fd.instr[14:12];
    assign funct7 = fd.instr[31:25];

    assign imm_i = {{20{fd.instr[31]}}, fd.instr[31:20]};
    assign imm_s = {{20{fd.instr[31]}}, fd.instr[31:25], fd.instr[11:7]};
    assign imm_b = {{19{fd.instr[31]}}, fd.instr[31], fd.instr[7], fd.instr[30:25],
                    fd.instr[11:8], 1'b0};

    always_comb begin
        ctrl    = '0;
        imm     = '0;
        legal   = 1'b0;
        use_rs2 = 1'b0;
        case (opcode)
            OP_R: begin
                ctrl.reg_write = 1'b1;
                use_rs2        = 1'b1;
                legal          = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: ctrl.alu_op = ALU_ADD;
                    {7'b0100000, 3'b000}: ctrl.alu_op = ALU_SUB;
                    {7'b0000000, 3'b010}: ctrl.alu_op = ALU_SLT;
                    {7'b0000000, 3'b110}: ctrl.alu_op = ALU_OR;
                    {7'b0000000, 3'b111}: ctrl.alu_op = ALU_AND;
                    default:              legal       = 1'b0;
                endcase
            end
            OP_IMM: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                imm              = imm_i;
                legal            = (funct3 == 3'b000);      // ADDI only
            end
            OP_LOAD: begin
                ctrl.reg_write   = 1'b1;
                ctrl.result_src  = RES_MEM;
                ctrl.alu_src_imm = 1'b1;
                imm              = imm_i;
                legal            = (funct3 == 3'b010);      // LW
            end
            OP_STORE: begin
                ctrl.mem_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                imm              = imm_s;
                use_rs2          = 1'b1;
                legal            = (funct3 == 3'b010);      // SW
            end
            OP_BRANCH: begin
                ctrl.branch = 1'b1;
                imm         = imm_b;
                use_rs2     = 1'b1;
                legal       = (funct3 == 3'b000);           // BEQ
            end
            default: legal = 1'b0;
        endcase

        if (!(legal && fd.valid)) begin
            ctrl    = '0;
            imm     = '0;
            use_rs2 = 1'b0;
        end

        // Unused fields read as x0 so they never match a hazard
        rs1 = (legal && fd.valid) ? fd.instr[19:15] : '0;
        rs2 = use_rs2 ? fd.instr[24:20] : '0;
        rd  = ctrl.reg_write ? fd.instr[11:7] : '0;
    end

endmodule

//--- reg_file.sv
`timescale 1ns/100ps

module reg_file import pipe_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [REG_ADDR_W-1:0] ra1,
    input  logic [REG_ADDR_W-1:0] ra2,
    output logic [XLEN-1:0]       rd1,
    output logic [XLEN-1:0]       rd2,
    input  logic                  we,
    input  logic [REG_ADDR_W-1:0] wa,
    input  logic [XLEN-1:0]       wd
);

    logic [XLEN-1:0] regs [2**REG_ADDR_W];
    logic            wr_live;

    assign wr_live = we && (wa != '0);      // x0 stays zero

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[wa] <= wd;
        end
    end

    // Writeback in the same cycle shows through to decode
    assign rd1 = (wr_live && wa == ra1) ? wd : regs[ra1];
    assign rd2 = (wr_live && wa == ra2) ? wd : regs[ra2];

endmodule

//--- fetch_stage.sv
`timescale 1ns/100ps

module fetch_stage import pipe_pkg::*; #(
    parameter int IMEM_DEPTH = 64
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            stall,
    input  logic            pc_src,
    input  logic [XLEN-1:0] pc_target,
    input  logic            imem_we,
    input  logic [XLEN-1:0] imem_addr,      // Byte address, word aligned
    input  logic [XLEN-1:0] imem_wdata,
    output fd_t             fd
);

    localparam int IAW = $clog2(IMEM_DEPTH);

    logic [XLEN-1:0] imem [IMEM_DEPTH];
    logic [XLEN-1:0] pc;

    always_ff @(posedge clk) begin
        if (rst && imem_we) begin
            imem[imem_addr[IAW+1:2]] <= imem_wdata;     // Program load only during reset
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (pc_src) begin
            pc <= pc_target;        // Taken branch from execute
        end else if (!stall) begin
            pc <= pc + XLEN'(4);
        end
    end

    assign fd.instr = imem[pc[IAW+1:2]];
    assign fd.pc    = pc;
    assign fd.valid = (pc < XLEN'(IMEM_DEPTH * 4));   // Past the array end decodes as NOP

endmodule

//--- pipe_reg.sv
`timescale 1ns/100ps

module pipe_reg #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic rst,
    input  logic stall,
    input  logic flush,
    input  T     d,
    output T     q
);

    // All-zero payload is a bubble: valid and write enables low
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            q <= '0;                // Flush beats stall
        end else if (!stall) begin
            q <= d;
        end
    end

endmodule

//--- pipe_pkg.sv
package pipe_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4
    } alu_op_e;

    typedef enum logic [1:0] {
        RES_ALU = 2'b00,
        RES_MEM = 2'b01,    // Load data, the code that marks a load
        RES_PC4 = 2'b10
    } result_src_e;

    typedef enum logic [1:0] {
        FWD_REG = 2'b00,    // Register file value
        FWD_WB  = 2'b01,
        FWD_MEM = 2'b10
    } fwd_sel_e;

    typedef struct packed {
        logic        reg_write;
        result_src_e result_src;
        logic        mem_write;
        logic        branch;
        logic        alu_src_imm;
        alu_op_e     alu_op;
    } ctrl_t;

    typedef struct packed {
        logic [XLEN-1:0] instr;
        logic [XLEN-1:0] pc;
        logic            valid;
    } fd_t;

    typedef struct packed {
        ctrl_t                 ctrl;
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       rd1;
        logic [XLEN-1:0]       rd2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       imm;
    } de_t;

    typedef struct packed {
        logic                  reg_write;
        result_src_e           result_src;
        logic                  mem_write;
        logic                  valid;
        logic [XLEN-1:0]       alu_result;
        logic [XLEN-1:0]       write_data;   // Store data after forwarding
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       pc_plus4;
    } em_t;

    typedef struct packed {
        logic                  reg_write;
        result_src_e           result_src;
        logic                  valid;
        logic [XLEN-1:0]       alu_result;
        logic [XLEN-1:0]       read_data;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       pc_plus4;
    } mw_t;

endpackage
